// ==== Makefile ====
# Verilator build and run of the co-processor testbench

sim:
	verilator --binary --timing --assert -f tb.f --top-module tb_cop_top
	./obj_dir/Vtb_cop_top | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== dv/tb_cop_top.sv ====
// Testbench for cop_top with clock, reset, CPU driver and memory model
// Handshake assertions and reference checks of results, CPRs and memory
`timescale 1ns/1ps
`default_nettype none

module tb_cop_top;
    import cop_pkg::*;

    logic        g_clk;
    logic        rst;
    logic        cpu_insn_req;
    logic [31:0] cpu_insn_enc;
    logic [31:0] cpu_rs1;
    logic        cpu_insn_ack;
    logic        cop_insn_ack;
    logic        cop_insn_rsp;
    logic [2:0]  cop_result;
    logic        cop_wen;
    logic [4:0]  cop_waddr;
    logic [31:0] cop_wdata;
    logic        cop_mem_cen;
    logic        cop_mem_wen;
    logic [31:0] cop_mem_addr;
    logic [31:0] cop_mem_wdata;
    logic [3:0]  cop_mem_ben;
    logic [31:0] cop_mem_rdata;
    logic        cop_mem_stall;
    logic        cop_mem_error;

    logic [31:0] mem [256];      // Memory model, 1 KiB of words
    logic [31:0] cpr_ref [16];   // Expected CPR contents
    logic [2:0]  got_result;     // Response captured when rsp rises
    logic        got_wen;
    logic [4:0]  got_waddr;
    logic [31:0] got_wdata;
    int          errors;
    int          tests;
    int          failed_tests;
    int          test_err0;
    int          stall_run;      // Consecutive stall cycles
    int          cen_count;      // Cycles with cen high
    bit          timed_out;

    cop_top dut_i (.*);

    initial g_clk = 1'b0;
    always #5 g_clk = ~g_clk;

    // Memory responds 1 ns after the edge, transfer ends on the next unstalled edge
    always begin
        @(posedge g_clk);
        #1;
        if (cop_mem_cen) begin
            cen_count++;
            if (stall_run < 3 && $urandom % 32'd2 == 32'd1) begin
                cop_mem_stall = 1'b1;
                stall_run++;
            end else begin
                cop_mem_stall = 1'b0;
                stall_run = 0;
            end
            cop_mem_error = cop_mem_addr >= 32'h400;  // Beyond the model
            cop_mem_rdata = mem[cop_mem_addr[9:2]];
            if (!cop_mem_stall && !cop_mem_error && cop_mem_wen) begin
                mem[cop_mem_addr[9:2]] = cop_mem_wdata;
            end
        end else begin
            cop_mem_stall = 1'b0;
            cop_mem_error = 1'b0;
            cop_mem_rdata = '0;
        end
    end

    ack_pulse: assert property (@(posedge g_clk) disable iff (rst)
            cop_insn_ack |=> !cop_insn_ack)
        else begin
            errors++;
            $display("ack held longer than one cycle at %0t", $time);
        end

    rsp_hold: assert property (@(posedge g_clk) disable iff (rst)
            cop_insn_rsp && !cpu_insn_ack |=> cop_insn_rsp && $stable(cop_result)
            && $stable(cop_wen) && $stable(cop_waddr) && $stable(cop_wdata))
        else begin
            errors++;
            $display("response changed before the core acknowledged it at %0t", $time);
        end

    no_ack_busy: assert property (@(posedge g_clk) disable iff (rst)
            cop_insn_rsp |-> !cop_insn_ack)
        else begin
            errors++;
            $display("new instruction acknowledged while a response was pending at %0t",
                     $time);
        end

    wen_in_rsp: assert property (@(posedge g_clk) disable iff (rst)
            cop_wen |-> cop_insn_rsp)
        else begin
            errors++;
            $display("cop_wen raised outside a response at %0t", $time);
        end

    mem_hold: assert property (@(posedge g_clk) disable iff (rst)
            cop_mem_cen && cop_mem_stall |=> cop_mem_cen && $stable(cop_mem_addr)
            && $stable(cop_mem_wdata) && $stable(cop_mem_wen))
        else begin
            errors++;
            $display("memory request dropped or changed during stall at %0t", $time);
        end

    store_ben: assert property (@(posedge g_clk) disable iff (rst)
            cop_mem_cen && cop_mem_wen |-> cop_mem_ben == 4'hf)
        else begin
            errors++;
            $display("MISMATCH at %0t: store byte enables %h", $time, cop_mem_ben);
        end

    function automatic logic [31:0] fill_word(input logic [7:0] idx);
        return 32'hc3a50000 ^ ({24'd0, idx} * 32'h01010101);  // Every address bit counts
    endfunction

    // Field layout: hi 31:27, subclass 26:23, class 22:20, crs2, crs1, crd, bit 7, opcode
    function automatic logic [31:0] encode(input logic [2:0] cls, input logic [3:0] sub,
                                           input logic [4:0] hi, input logic [3:0] crd,
                                           input logic [3:0] crs1, input logic [3:0] crs2);
        return {hi, sub, cls, crs2, crs1, crd, 1'b0, 7'h0b};
    endfunction

    // Lane-wise add or subtract, lanes of 32 >> pw bits
    function automatic logic [31:0] lane_arith(input logic [31:0] a, input logic [31:0] b,
                                               input logic [1:0] pw, input bit sub);
        logic [31:0] r;
        logic [31:0] mask;
        int          w;
        w = 32 >> pw;
        mask = (w == 32) ? 32'hffffffff : (32'd1 << w) - 32'd1;
        r = '0;
        for (int s = 0; s < 32; s += w) begin
            r |= ((sub ? (a >> s) - (b >> s) : (a >> s) + (b >> s)) & mask) << s;
        end
        return r;
    endfunction

    task automatic issue(input logic [31:0] enc, input logic [31:0] rs1);
        int n;
        if (timed_out) return;
        cpu_insn_req = 1'b1;
        cpu_insn_enc = enc;
        cpu_rs1      = rs1;
        n = 0;
        while (!cop_insn_ack && n < 200) begin
            @(posedge g_clk);
            #1;
            n++;
        end
        if (!cop_insn_ack) begin
            $display("timeout: no ack from the DUT for instruction %h", enc);
            errors++;
            timed_out = 1'b1;
            cpu_insn_req = 1'b0;
            return;
        end
        @(posedge g_clk);  // Accepting edge
        #1;
        cpu_insn_req = 1'b0;
        cpu_insn_enc = $urandom;  // DUT must have latched it
        n = 0;
        while (!cop_insn_rsp && n < 200) begin
            @(posedge g_clk);
            #1;
            n++;
        end
        if (!cop_insn_rsp) begin
            $display("timeout: no response from the DUT for instruction %h", enc);
            errors++;
            timed_out = 1'b1;
            return;
        end
        got_result = cop_result;
        got_wen    = cop_wen;
        got_waddr  = cop_waddr;
        got_wdata  = cop_wdata;
        cpu_insn_req = 1'b1;  // Offer while the response is still pending
        cpu_insn_enc = $urandom;
        repeat ($urandom % 4) begin  // Back-pressure gap
            @(posedge g_clk);
            #1;
        end
        cpu_insn_ack = 1'b1;
        @(posedge g_clk);
        #1;
        cpu_insn_ack = 1'b0;
        cpu_insn_req = 1'b0;  // Withdrawn before the DUT leaves idle
    endtask

    task automatic expect_rsp(input logic [2:0] res, input logic wen, input logic [31:0] wdata,
                              input logic [4:0] waddr, input string what);
        if (timed_out) return;
        assert (got_result == res) else begin
            errors++;
            $display("MISMATCH at %0t: %s result %0d, expected %0d", $time, what, got_result,
                     res);
        end
        assert (got_wen == wen) else begin
            errors++;
            $display("MISMATCH at %0t: %s cop_wen %b, expected %b", $time, what, got_wen, wen);
        end
        if (wen) begin
            assert (got_wdata == wdata && got_waddr == waddr) else begin
                errors++;
                $display("MISMATCH at %0t: %s wrote %h to x%0d, expected %h to x%0d", $time,
                         what, got_wdata, got_waddr, wdata, waddr);
            end
        end
    endtask

    task automatic write_cpr(input logic [3:0] c, input logic [31:0] v);
        issue(encode(MOVE, GPR2CPR, 5'($urandom), c, 4'($urandom), 4'($urandom)), v);
        expect_rsp(SUCCESS, 1'b0, '0, '0, "gpr2cpr");
        cpr_ref[c] = v;
    endtask

    // MV2GPR readback to a random GPR
    task automatic check_cpr(input logic [3:0] c);
        logic [3:0]  rdh;
        logic        b7;
        logic [31:0] enc;
        rdh = 4'($urandom);
        b7  = 1'($urandom);
        enc = encode(MOVE, MV2GPR, 5'($urandom), rdh, c, 4'($urandom)) | {24'd0, b7, 7'd0};
        issue(enc, $urandom);
        expect_rsp(SUCCESS, 1'b1, cpr_ref[c], {rdh, b7}, "mv2gpr");
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors != test_err0) failed_tests++;
        $display("test %s: %s", name, (errors == test_err0) ? "ok" : "FAILED");
        test_err0 = errors;
    endtask

    initial begin
        logic [31:0] seed;
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] base;
        logic [31:0] addr;
        logic [4:0]  off;
        logic [3:0]  a;
        logic [3:0]  b;
        logic [3:0]  d;
        logic [31:0] bad [4];
        cop_sclass_t op;
        int          cen0;
        bit          is_sub;
        seed = $urandom(32'h5c8bf0fa);
        rst = 1'b1;
        cpu_insn_req = 1'b0;
        cpu_insn_enc = '0;
        cpu_rs1 = '0;
        cpu_insn_ack = 1'b0;
        cop_mem_rdata = '0;
        cop_mem_stall = 1'b0;
        cop_mem_error = 1'b0;
        errors = 0;
        tests = 0;
        failed_tests = 0;
        test_err0 = 0;
        stall_run = 0;
        cen_count = 0;
        timed_out = 1'b0;
        for (int i = 0; i < 256; i++) mem[i] = fill_word(8'(i));
        for (int i = 0; i < 16; i++) cpr_ref[i] = '0;
        repeat (16) @(posedge g_clk);
        #1;
        rst = 1'b0;
        assert (!cop_insn_ack && !cop_insn_rsp && !cop_wen && !cop_mem_cen) else begin
            errors++;
            $display("MISMATCH at %0t: outputs not idle after reset", $time);
        end
        check_cpr(4'd9);  // Reset value of a CPR
        write_cpr(4'd9, $urandom);
        check_cpr(4'd9);
        end_test("reset_handshake");

        for (int c = 0; c < 16; c++) write_cpr(4'(c), $urandom);
        for (int k = 0; k < 9; k++) begin
            a  = 4'($urandom);
            b  = 4'($urandom);
            d  = 4'($urandom);
            op = (k % 3 == 0) ? XOR : (k % 3 == 1) ? AND : OR;
            x  = (op == XOR) ? cpr_ref[a] ^ cpr_ref[b]
               : (op == AND) ? cpr_ref[a] & cpr_ref[b] : cpr_ref[a] | cpr_ref[b];
            issue(encode(BITWISE, op, 5'($urandom), d, a, b), $urandom);
            expect_rsp(SUCCESS, 1'b0, '0, '0, "bitwise");
            cpr_ref[d] = x;
            check_cpr(d);
        end
        end_test("move_bitwise");

        for (int p = 0; p < 3; p++) begin
            for (int k = 0; k < 6; k++) begin
                is_sub = k % 2 == 1;
                x = (k < 2) ? (is_sub ? 32'h0 : 32'hffffffff) : $urandom;  // Lane overflow
                y = (k < 2) ? 32'h01010101 : $urandom;
                write_cpr(4'd1, x);
                write_cpr(4'd2, y);
                issue(encode(PACKED_ARITH, is_sub ? SUB : ADD, {3'($urandom), 2'(p)},
                             4'd3, 4'd1, 4'd2), $urandom);
                expect_rsp(SUCCESS, 1'b0, '0, '0, "packed");
                cpr_ref[3] = lane_arith(x, y, 2'(p), is_sub);
                check_cpr(4'd3);
            end
        end
        end_test("packed_arith");

        for (int k = 0; k < 3; k++) begin
            write_cpr(4'd4, $urandom);
            base = 32'h200 + 4 * ($urandom % 64);
            off  = 5'($urandom);
            addr = base + {{25{off[4]}}, off, 2'b00};  // rs1 + 4 * imm
            issue(encode(LOADSTORE, SW, off, 4'd4, 4'd0, 4'd0), base);
            expect_rsp(SUCCESS, 1'b0, '0, '0, "sw");
            assert (timed_out || mem[addr[9:2]] == cpr_ref[4]) else begin
                errors++;
                $display("MISMATCH at %0t: memory %h holds %h", $time, addr, mem[addr[9:2]]);
            end
            issue(encode(LOADSTORE, LW, 5'd0, 4'd5, 4'd0, 4'd0), addr);
            expect_rsp(SUCCESS, 1'b0, '0, '0, "lw");
            cpr_ref[5] = cpr_ref[4];
            check_cpr(4'd5);
            addr = 4 * (1 + $urandom % 63);  // Below the store window
            issue(encode(LOADSTORE, LW, 5'd1, 4'd6, 4'd0, 4'd0), addr - 32'd4);
            expect_rsp(SUCCESS, 1'b0, '0, '0, "lw fill");
            cpr_ref[6] = fill_word(addr[9:2]);
            check_cpr(4'd6);
        end
        end_test("load_store");

        cen0 = cen_count;
        issue(encode(LOADSTORE, SW, 5'd0, 4'd4, 4'd0, 4'd0), 32'h102);
        expect_rsp(BAD_LAD, 1'b0, '0, '0, "misaligned sw");
        issue(encode(LOADSTORE, LW, 5'd0, 4'd5, 4'd0, 4'd0), 32'h201);
        expect_rsp(BAD_LAD, 1'b0, '0, '0, "misaligned lw");
        assert (cen_count == cen0) else begin
            errors++;
            $display("memory was accessed for a misaligned address at %0t", $time);
        end
        check_cpr(4'd5);
        issue(encode(LOADSTORE, LW, 5'd0, 4'd5, 4'd0, 4'd0), 32'h400);
        expect_rsp(LD_ERR, 1'b0, '0, '0, "lw bus error");
        check_cpr(4'd5);
        issue(encode(LOADSTORE, SW, 5'd0, 4'd5, 4'd0, 4'd0), 32'h7f0);
        expect_rsp(LD_ERR, 1'b0, '0, '0, "sw bus error");
        bad[0] = encode(BITWISE, XOR, 5'd0, 4'd7, 4'd1, 4'd2) ^ 32'h1;  // Wrong opcode
        bad[1] = encode(3'd5, ADD, 5'd0, 4'd7, 4'd1, 4'd2);              // Undefined class
        bad[2] = encode(PACKED_ARITH, ADD, 5'd3, 4'd7, 4'd1, 4'd2);      // Pack width 3
        bad[3] = encode(MOVE, XOR, 5'd0, 4'd7, 4'd1, 4'd2);              // Foreign subclass
        for (int i = 0; i < 4; i++) begin
            issue(bad[i], $urandom);
            expect_rsp(BAD_INS, 1'b0, '0, '0, "illegal");
        end
        check_cpr(4'd7);
        end_test("errors");

        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/cop_cprs.sv ====
// CPR file, three combinational reads and one byte-enabled write
`timescale 1ns/1ps
`include "cop_macros.svh"
`default_nettype none

module cop_cprs (
    input  logic                   g_clk,
    input  logic                   rst,
    input  logic [3:0]             rs1_addr,
    input  logic [3:0]             rs2_addr,
    input  logic [3:0]             rs3_addr,
    output logic [`COP_XLEN-1:0]   rs1_data,
    output logic [`COP_XLEN-1:0]   rs2_data,
    output logic [`COP_XLEN-1:0]   rs3_data,
    input  logic [`COP_XLEN/8-1:0] wr_ben,
    input  logic [3:0]             wr_addr,
    input  logic [`COP_XLEN-1:0]   wr_data
);

    logic [`COP_XLEN-1:0] regs [`COP_NCPR];

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];
    assign rs3_data = regs[rs3_addr];  // Old crd value

    always_ff @(posedge g_clk) begin
        if (rst) begin
            for (int i = 0; i < `COP_NCPR; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int b = 0; b < `COP_XLEN/8; b++) begin
                if (wr_ben[b]) begin
                    regs[wr_addr][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/cop_fu_if.sv ====
// Dispatch interface between control and one functional unit
`timescale 1ns/1ps
`include "cop_macros.svh"
`default_nettype none

interface cop_fu_if;
    import cop_pkg::*;

    logic                     ivalid;    // One-cycle dispatch pulse
    cop_insn_t                insn;      // Latched decoded instruction
    logic                     idone;     // One-cycle completion pulse
    logic [`COP_XLEN/8-1:0]   rd_ben;    // CPR byte write enables
    logic [`COP_XLEN-1:0]     rd_wdata;  // Zero outside idone
    cop_result_t              result;    // Zero outside idone

    modport ctrl (
        output ivalid, insn,
        input  idone, rd_ben, rd_wdata, result
    );

    modport unit (
        input  ivalid, insn,
        output idone, rd_ben, rd_wdata, result
    );

endinterface

`default_nettype wire

// ==== hw/cop_idecode.sv ====
// Combinational instruction decoder with all legality checks
`timescale 1ns/1ps
`include "cop_macros.svh"
`default_nettype none

module cop_idecode (
    input  logic [31:0]       insn_enc,
    output cop_pkg::cop_insn_t insn
);
    import cop_pkg::*;

    logic ok;  // Class, subclass and pack width all consistent

    always_comb begin
        insn        = '0;
        insn.sclass = cop_sclass_t'(insn_enc[26:23]);
        insn.pw     = insn_enc[28:27];
        insn.crd    = insn_enc[11:8];
        insn.crs1   = insn_enc[15:12];
        insn.crs2   = insn_enc[19:16];
        insn.rd     = insn_enc[11:7];
        insn.imm    = {{27{insn_enc[31]}}, insn_enc[31:27]};  // Sign extended
        ok          = 1'b0;

        case (insn_enc[22:20])
            3'd0: begin
                insn.iclass = PACKED_ARITH;
                ok = (insn.sclass == ADD || insn.sclass == SUB) && insn.pw != 2'd3;
            end
            3'd1: begin
                insn.iclass = BITWISE;
                ok = insn.sclass == XOR || insn.sclass == AND || insn.sclass == OR;
            end
            3'd2: begin
                insn.iclass = MOVE;
                ok = insn.sclass == GPR2CPR || insn.sclass == MV2GPR;
            end
            3'd3: begin
                insn.iclass = LOADSTORE;
                ok = insn.sclass == LW || insn.sclass == SW;
            end
            default: ok = 1'b0;  // Undefined class
        endcase

        if (insn_enc[6:0] != `COP_OPCODE) begin
            ok = 1'b0;
        end

        insn.illegal = !ok;
        if (!ok) begin
            insn.iclass = ILLEGAL;
        end
    end

endmodule

`default_nettype wire

// ==== hw/cop_macros.svh ====
// Word width, CPR count and custom opcode constants
`default_nettype none

`ifndef COP_MACROS_SVH
`define COP_MACROS_SVH

`define COP_XLEN    32     // Data word width
`define COP_NCPR    16     // Number of CPRs, 4-bit addresses
`define COP_OPCODE  7'h0B  // custom-0 major opcode, bits 6:0

`endif

`default_nettype wire

// ==== hw/cop_mem.sv ====
// Load/store unit, word access with alignment check and stall hold
// Captures bus errors as LD_ERR
`timescale 1ns/1ps
`include "cop_macros.svh"
`default_nettype none

module cop_mem (
    input  logic                   g_clk,
    input  logic                   rst,
    cop_fu_if.unit                 fu,
    input  logic [`COP_XLEN-1:0]   gpr_rs1,
    input  logic [`COP_XLEN-1:0]   store_data,
    output logic                   mem_cen,
    output logic                   mem_wen,
    output logic [`COP_XLEN-1:0]   mem_addr,
    output logic [`COP_XLEN-1:0]   mem_wdata,
    output logic [`COP_XLEN/8-1:0] mem_ben,
    input  logic [`COP_XLEN-1:0]   mem_rdata,
    input  logic                   mem_stall,
    input  logic                   mem_error
);
    import cop_pkg::*;

    typedef enum logic {MS_IDLE, MS_BUS} mstate_t;

    mstate_t              state;
    logic [`COP_XLEN-1:0] addr;
    logic                 start;  // Accepted aligned request
    logic                 xfer;   // Transfer completes this cycle
    logic                 is_lw;

    assign addr  = gpr_rs1 + {fu.insn.imm[`COP_XLEN-3:0], 2'b00};  // rs1 + 4*imm
    assign start = state == MS_IDLE && fu.ivalid && addr[1:0] == 2'b00;
    assign xfer  = state == MS_BUS && !mem_stall;
    assign is_lw = fu.insn.sclass == LW;

    always_ff @(posedge g_clk) begin
        if (rst) begin
            state     <= MS_IDLE;
            mem_cen   <= 1'b0;
            mem_wen   <= 1'b0;
            mem_ben   <= '0;
            fu.idone  <= 1'b0;
            fu.rd_ben <= '0;
            fu.result <= SUCCESS;
        end else begin
            fu.idone  <= 1'b0;
            fu.rd_ben <= '0;
            fu.result <= SUCCESS;
            if (state == MS_IDLE && fu.ivalid && !start) begin
                fu.idone  <= 1'b1;  // Misaligned, no bus access
                fu.result <= BAD_LAD;
            end
            if (start) begin
                state   <= MS_BUS;
                mem_cen <= 1'b1;
                mem_wen <= !is_lw;
                mem_ben <= is_lw ? '0 : '1;
            end
            if (xfer) begin
                state    <= MS_IDLE;
                mem_cen  <= 1'b0;
                mem_wen  <= 1'b0;
                mem_ben  <= '0;
                fu.idone <= 1'b1;
                if (mem_error) begin
                    fu.result <= LD_ERR;  // No CPR write
                end else if (is_lw) begin
                    fu.rd_ben <= '1;
                end
            end
        end
    end

    always_ff @(posedge g_clk) begin
        fu.rd_wdata <= (xfer && is_lw && !mem_error) ? mem_rdata : '0;
        if (start) begin
            mem_addr  <= addr;
            mem_wdata <= store_data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/cop_palu.sv ====
// Packed add/sub, bitwise and move unit
// Result registered one cycle after ivalid
`timescale 1ns/1ps
`include "cop_macros.svh"
`default_nettype none

module cop_palu (
    input  logic                 g_clk,
    input  logic                 rst,
    cop_fu_if.unit               fu,
    input  logic [`COP_XLEN-1:0] gpr_rs1,
    input  logic [`COP_XLEN-1:0] rs1_data,
    input  logic [`COP_XLEN-1:0] rs2_data
);
    import cop_pkg::*;

    logic                     sub;        // Subtract, invert and inject carry
    logic [`COP_XLEN-1:0]     b_op;
    logic [`COP_XLEN-1:0]     arith;      // Lane-wise sum or difference
    logic [8:0]               sum9;
    logic                     carry;
    logic [`COP_XLEN-1:0]     nxt_wdata;
    logic [`COP_XLEN/8-1:0]   nxt_ben;

    assign sub  = fu.insn.sclass == SUB;
    assign b_op = sub ? ~rs2_data : rs2_data;

    // Byte-wise ripple, carry restarts at each lane border
    always_comb begin
        carry = sub;
        sum9  = '0;
        arith = '0;
        for (int b = 0; b < `COP_XLEN/8; b++) begin
            if (b == 0 || fu.insn.pw == 2'd2 || (fu.insn.pw == 2'd1 && b == 2)) begin
                carry = sub;  // Lane start
            end
            sum9 = {1'b0, rs1_data[8*b +: 8]} + {1'b0, b_op[8*b +: 8]} + {8'd0, carry};
            arith[8*b +: 8] = sum9[7:0];
            carry = sum9[8];
        end
    end

    always_comb begin
        nxt_ben   = '1;
        nxt_wdata = arith;
        case (fu.insn.sclass)
            XOR:     nxt_wdata = rs1_data ^ rs2_data;
            AND:     nxt_wdata = rs1_data & rs2_data;
            OR:      nxt_wdata = rs1_data | rs2_data;
            GPR2CPR: nxt_wdata = gpr_rs1;
            MV2GPR: begin
                nxt_wdata = rs1_data;  // Goes to the GPR port
                nxt_ben   = '0;
            end
            default: nxt_wdata = arith;
        endcase
    end

    assign fu.result = SUCCESS;

    always_ff @(posedge g_clk) begin
        if (rst) begin
            fu.idone  <= 1'b0;
            fu.rd_ben <= '0;
        end else begin
            fu.idone  <= fu.ivalid;
            fu.rd_ben <= fu.ivalid ? nxt_ben : '0;
        end
    end

    // Zero when idle so top can OR the units together
    always_ff @(posedge g_clk) begin
        fu.rd_wdata <= fu.ivalid ? nxt_wdata : '0;
    end

endmodule

`default_nettype wire

// ==== hw/cop_pkg.sv ====
// Instruction class, subclass and result encodings
// Decoded instruction struct shared by decoder and functional units
`default_nettype none

package cop_pkg;

    // Class field, encoding bits 22:20
    typedef enum logic [2:0] {
        PACKED_ARITH = 3'd0,
        BITWISE      = 3'd1,
        MOVE         = 3'd2,
        LOADSTORE    = 3'd3,
        ILLEGAL      = 3'd7
    } cop_iclass_t;

    // Subclass field, encoding bits 26:23
    typedef enum logic [3:0] {
        ADD     = 4'd0,   // Packed arithmetic
        SUB     = 4'd1,
        XOR     = 4'd2,   // Bitwise
        AND     = 4'd3,
        OR      = 4'd4,
        GPR2CPR = 4'd5,   // Move
        MV2GPR  = 4'd6,
        LW      = 4'd7,   // Load/store
        SW      = 4'd8
    } cop_sclass_t;

    // Result code returned to the core
    typedef enum logic [2:0] {
        SUCCESS = 3'd0,
        BAD_INS = 3'd1,   // Illegal instruction
        BAD_LAD = 3'd2,   // Misaligned address
        LD_ERR  = 3'd3    // Bus error
    } cop_result_t;

    typedef struct packed {
        cop_iclass_t iclass;
        cop_sclass_t sclass;
        logic [1:0]  pw;       // 0 word, 1 halfword lanes, 2 byte lanes
        logic [3:0]  crd;
        logic [3:0]  crs1;
        logic [3:0]  crs2;
        logic [4:0]  rd;       // GPR destination for MV2GPR
        logic [31:0] imm;      // Word offset for load/store
        logic        illegal;
    } cop_insn_t;

endpackage

`default_nettype wire

// ==== hw/cop_top.sv ====
// Co-processor top, CPU handshake FSM, instruction latch, dispatch
// CPR writeback selection and held response registers
`timescale 1ns/1ps
`include "cop_macros.svh"
`default_nettype none

module cop_top (
    input  logic                   g_clk,
    input  logic                   rst,
    input  logic                   cpu_insn_req,
    input  logic [31:0]            cpu_insn_enc,
    input  logic [`COP_XLEN-1:0]   cpu_rs1,
    input  logic                   cpu_insn_ack,
    output logic                   cop_insn_ack,
    output logic                   cop_insn_rsp,
    output logic [2:0]             cop_result,
    output logic                   cop_wen,
    output logic [4:0]             cop_waddr,
    output logic [`COP_XLEN-1:0]   cop_wdata,
    output logic                   cop_mem_cen,
    output logic                   cop_mem_wen,
    output logic [`COP_XLEN-1:0]   cop_mem_addr,
    output logic [`COP_XLEN-1:0]   cop_mem_wdata,
    output logic [`COP_XLEN/8-1:0] cop_mem_ben,
    input  logic [`COP_XLEN-1:0]   cop_mem_rdata,
    input  logic                   cop_mem_stall,
    input  logic                   cop_mem_error
);
    import cop_pkg::*;

    typedef enum logic [1:0] {IDLE, ACK, EXEC, RSP} state_t;

    state_t               state;
    cop_insn_t            dec;      // Decode of the offered encoding
    cop_insn_t            insn_q;   // Latched instruction
    logic [`COP_XLEN-1:0] rs1_q;
    logic                 accept;   // req and ack both high
    logic                 fu_done;
    cop_result_t          result_q;
    logic                 wen_q;
    logic [`COP_XLEN-1:0] wdata_q;
    logic [`COP_XLEN-1:0] crs1_data;
    logic [`COP_XLEN-1:0] crs2_data;
    logic [`COP_XLEN-1:0] crd_data;

    cop_fu_if palu_if ();
    cop_fu_if mem_if ();

    assign cop_insn_ack = state == ACK;
    assign cop_insn_rsp = state == RSP;
    assign accept       = cop_insn_ack && cpu_insn_req;
    assign fu_done      = palu_if.idone || mem_if.idone;

    assign palu_if.insn = insn_q;
    assign mem_if.insn  = insn_q;

    assign cop_result = result_q;
    assign cop_wen    = wen_q;
    assign cop_waddr  = insn_q.rd;
    assign cop_wdata  = wdata_q;

    cop_idecode idecode_i (
        .insn_enc (cpu_insn_enc),  // Stable while ACK is up
        .insn     (dec)
    );

    always_ff @(posedge g_clk) begin
        if (rst) begin
            state          <= IDLE;
            palu_if.ivalid <= 1'b0;
            mem_if.ivalid  <= 1'b0;
            wen_q          <= 1'b0;
        end else begin
            palu_if.ivalid <= 1'b0;
            mem_if.ivalid  <= 1'b0;
            case (state)
                IDLE: if (cpu_insn_req) state <= ACK;
                ACK: begin
                    if (!cpu_insn_req) begin
                        state <= IDLE;
                    end else if (dec.illegal) begin
                        state <= RSP;  // Skip dispatch
                    end else begin
                        state          <= EXEC;
                        palu_if.ivalid <= dec.iclass != LOADSTORE;
                        mem_if.ivalid  <= dec.iclass == LOADSTORE;
                    end
                end
                EXEC: begin
                    if (fu_done) begin
                        state <= RSP;
                        wen_q <= palu_if.idone && insn_q.sclass == MV2GPR;
                    end
                end
                RSP: begin
                    if (cpu_insn_ack) begin
                        state <= IDLE;
                        wen_q <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Instruction latch and held response data
    always_ff @(posedge g_clk) begin
        if (accept) begin
            insn_q   <= dec;
            rs1_q    <= cpu_rs1;
            result_q <= dec.illegal ? BAD_INS : SUCCESS;
        end
        if (state == EXEC && fu_done) begin
            result_q <= cop_result_t'(palu_if.result | mem_if.result);
            wdata_q  <= palu_if.rd_wdata;  // MV2GPR value
        end
    end

    cop_cprs cprs_i (
        .g_clk    (g_clk),
        .rst      (rst),
        .rs1_addr (insn_q.crs1),
        .rs2_addr (insn_q.crs2),
        .rs3_addr (insn_q.crd),
        .rs1_data (crs1_data),
        .rs2_data (crs2_data),
        .rs3_data (crd_data),
        .wr_ben   (palu_if.rd_ben | mem_if.rd_ben),      // Idle unit drives zero
        .wr_addr  (insn_q.crd),
        .wr_data  (palu_if.rd_wdata | mem_if.rd_wdata)
    );

    cop_palu palu_i (
        .g_clk    (g_clk),
        .rst      (rst),
        .fu       (palu_if.unit),
        .gpr_rs1  (rs1_q),
        .rs1_data (crs1_data),
        .rs2_data (crs2_data)
    );

    cop_mem mem_i (
        .g_clk      (g_clk),
        .rst        (rst),
        .fu         (mem_if.unit),
        .gpr_rs1    (rs1_q),
        .store_data (crd_data),  // SW stores crd
        .mem_cen    (cop_mem_cen),
        .mem_wen    (cop_mem_wen),
        .mem_addr   (cop_mem_addr),
        .mem_wdata  (cop_mem_wdata),
        .mem_ben    (cop_mem_ben),
        .mem_rdata  (cop_mem_rdata),
        .mem_stall  (cop_mem_stall),
        .mem_error  (cop_mem_error)
    );

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+hw
hw/cop_pkg.sv
hw/cop_fu_if.sv
hw/cop_idecode.sv
hw/cop_cprs.sv
hw/cop_palu.sv
hw/cop_mem.sv
hw/cop_top.sv
dv/tb_cop_top.sv
